/* project.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/mem_addr_stage.sv
rtl/mem_op_stage.sv
rtl/dual_port_ram.sv
rtl/mem_pipe_top.sv
sim/mem_pipe_sva.sv
sim/tb_mem_pipe.sv

/* rtl/dual_port_ram.sv */
`include "sizes_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module dual_port_ram (
    input  logic            iw_clk,
    input  logic            iw_rst,
    input  pipe_pkg::addr_t port_addr [0:1],
    input  logic [1:0]      port_addr_we,
    input  logic            sel,
    input  logic            wr_en,
    input  pipe_pkg::data_t wr_data,
    output pipe_pkg::data_t rd_data
);
    import pipe_pkg::*;

    data_t mem [`MEM_DEPTH];
    addr_t addr_q [0:1];
    addr_t cur_addr;

    // Every word starts at zero so an early load returns 0
    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // One address register per port, loaded only on its own strobe
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            addr_q[0] <= '0;
            addr_q[1] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (port_addr_we[i]) begin
                    addr_q[i] <= port_addr[i];
                end
            end
        end
    end

    assign cur_addr = addr_q[sel];

    // Read is asynchronous, a store shows up to the next cycle's reader
    assign rd_data = mem[cur_addr];

    always @(posedge iw_clk) begin
        if (wr_en) begin
            mem[cur_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // Decoded operation class as it reaches the back end
    typedef enum logic [1:0] {
        OPC_NOP = 2'd0,
        OPC_ALU = 2'd1,
        OPC_LD  = 2'd2,
        OPC_ST  = 2'd3
    } opcode_t;

    // True for every opcode that touches the data memory
    function automatic logic is_mem_op(input opcode_t opc);
        logic hit;
        hit = (opc == OPC_LD) || (opc == OPC_ST);
        return hit;
    endfunction

endpackage

`default_nettype wire

/* rtl/mem_addr_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_addr_stage (
    input  logic              iw_clk,
    input  logic              iw_rst,
    input  logic              stall,
    input  isa_pkg::opcode_t  in_opc,
    input  pipe_pkg::gp_idx_t in_tgt_gp,
    input  logic              in_tgt_gp_we,
    input  logic              in_trap_pending,
    input  pipe_pkg::addr_t   in_addr,
    input  pipe_pkg::data_t   in_result,
    output isa_pkg::opcode_t  opc,
    output pipe_pkg::gp_idx_t tgt_gp,
    output logic              tgt_gp_we,
    output pipe_pkg::data_t   result,
    output logic              trap_pending,
    output logic              mem_mp,
    output pipe_pkg::addr_t   port_addr [0:1],
    output logic [1:0]        port_addr_we
);
    import isa_pkg::*;

    logic in_is_mem;
    logic ma_port;

    assign in_is_mem = is_mem_op(in_opc);

    // MO works on port mem_mp during the next cycle, so MA takes the other one
    assign ma_port = ~mem_mp;

    // Control part of the stage register
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            opc          <= OPC_NOP;
            tgt_gp_we    <= 1'b0;
            trap_pending <= 1'b0;
            mem_mp       <= 1'b0;
        end else if (!stall) begin
            opc          <= in_opc;
            tgt_gp_we    <= in_tgt_gp_we;
            trap_pending <= in_trap_pending;
            // The flip lands on the same edge that latches the address
            if (in_is_mem) begin
                mem_mp <= ~mem_mp;
            end
        end
    end

    // Payload part of the stage register
    always_ff @(posedge iw_clk) begin
        if (!stall) begin
            tgt_gp <= in_tgt_gp;
            result <= in_result;
        end
    end

    // Address steering toward the memory
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            port_addr[i]    = '0;
            port_addr_we[i] = 1'b0;
        end
        port_addr[ma_port]    = in_addr;
        // No strobe while stalled, the held instruction strobes once on release
        port_addr_we[ma_port] = in_is_mem && !stall;
    end

endmodule

`default_nettype wire

/* rtl/mem_op_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_op_stage (
    input  logic              iw_clk,
    input  logic              iw_rst,
    input  logic              stall,
    input  isa_pkg::opcode_t  opc,
    input  pipe_pkg::gp_idx_t tgt_gp,
    input  logic              tgt_gp_we,
    input  pipe_pkg::data_t   result,
    input  logic              trap_pending,
    input  logic              mem_mp,
    input  pipe_pkg::data_t   rd_data,
    output logic              sel,
    output logic              wr_en,
    output pipe_pkg::data_t   wr_data,
    output logic              wb_we,
    output pipe_pkg::gp_idx_t wb_tgt,
    output pipe_pkg::data_t   wb_data,
    output logic              trap_out
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic  is_mem;
    logic  is_store;
    logic  is_load;
    logic  is_alu;
    logic  live;
    logic  wb_en;
    data_t wb_next;

    assign is_mem   = is_mem_op(opc);
    assign is_store = is_mem && (opc == OPC_ST);
    assign is_load  = is_mem && !is_store;
    assign is_alu   = (opc == OPC_ALU);

    // An instruction has effects only on an unstalled edge and without a trap
    assign live = !stall && !trap_pending;

    // MA latched this instruction's address into port mem_mp one edge ago
    assign sel = mem_mp;

    assign wr_en   = live && is_store;
    assign wr_data = result;

    // Stores and NOPs never write a general register
    assign wb_en   = live && tgt_gp_we && (is_alu || is_load);
    assign wb_next = is_load ? rd_data : result;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            wb_we    <= 1'b0;
            trap_out <= 1'b0;
        end else begin
            wb_we    <= wb_en;
            // One pulse per trapped instruction since MA holds it while stalled
            trap_out <= !stall && trap_pending;
        end
    end

    // The record keeps its last value between write-backs
    always_ff @(posedge iw_clk) begin
        if (wb_en) begin
            wb_tgt  <= tgt_gp;
            wb_data <= wb_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_top (
    input  logic              iw_clk,
    input  logic              iw_rst,
    input  logic              stall,
    input  isa_pkg::opcode_t  in_opc,
    input  pipe_pkg::gp_idx_t in_tgt_gp,
    input  logic              in_tgt_gp_we,
    input  pipe_pkg::addr_t   in_addr,
    input  pipe_pkg::data_t   in_result,
    input  logic              in_trap_pending,
    output logic              wb_we,
    output pipe_pkg::gp_idx_t wb_tgt,
    output pipe_pkg::data_t   wb_data,
    output logic              trap_out
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // MA to MO
    opcode_t    ma_opc;
    gp_idx_t    ma_tgt_gp;
    logic       ma_tgt_gp_we;
    data_t      ma_result;
    logic       ma_trap_pending;
    logic       mem_mp;

    // MA to memory
    addr_t      port_addr [0:1];
    logic [1:0] port_addr_we;

    // MO to memory and back
    logic       mem_sel;
    logic       wr_en;
    data_t      wr_data;
    data_t      rd_data;

    mem_addr_stage u_ma (
        .iw_clk          (iw_clk),
        .iw_rst          (iw_rst),
        .stall           (stall),
        .in_opc          (in_opc),
        .in_tgt_gp       (in_tgt_gp),
        .in_tgt_gp_we    (in_tgt_gp_we),
        .in_trap_pending (in_trap_pending),
        .in_addr         (in_addr),
        .in_result       (in_result),
        .opc             (ma_opc),
        .tgt_gp          (ma_tgt_gp),
        .tgt_gp_we       (ma_tgt_gp_we),
        .result          (ma_result),
        .trap_pending    (ma_trap_pending),
        .mem_mp          (mem_mp),
        .port_addr       (port_addr),
        .port_addr_we    (port_addr_we)
    );

    mem_op_stage u_mo (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .stall        (stall),
        .opc          (ma_opc),
        .tgt_gp       (ma_tgt_gp),
        .tgt_gp_we    (ma_tgt_gp_we),
        .result       (ma_result),
        .trap_pending (ma_trap_pending),
        .mem_mp       (mem_mp),
        .rd_data      (rd_data),
        .sel          (mem_sel),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .wb_we        (wb_we),
        .wb_tgt       (wb_tgt),
        .wb_data      (wb_data),
        .trap_out     (trap_out)
    );

    dual_port_ram u_ram (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .port_addr    (port_addr),
        .port_addr_we (port_addr_we),
        .sel          (mem_sel),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .rd_data      (rd_data)
    );

endmodule

`default_nettype wire

/* rtl/pipe_pkg.sv */
`include "sizes_defines.svh"

`default_nettype none

package pipe_pkg;

    // Data memory address
    typedef logic [`SIZE_ADDR-1:0] addr_t;

    // Register value, memory word and store data
    typedef logic [`SIZE_DATA-1:0] data_t;

    // General register index for write-back
    typedef logic [`SIZE_TGT_GP-1:0] gp_idx_t;

endpackage

`default_nettype wire

/* rtl/sizes_defines.svh */
`ifndef SIZES_DEFINES_SVH
`define SIZES_DEFINES_SVH

// Byte-free word addressing, one address selects one data word
`define SIZE_ADDR 8

// Width of a general register and of a memory word
`define SIZE_DATA 16

// General register index, sixteen registers
`define SIZE_TGT_GP 4

// Words in the data memory, covers the whole address space
`define MEM_DEPTH 256

`endif

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
    --top-module tb_mem_pipe -o tb_mem_pipe
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_mem_pipe
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0

/* sim/mem_pipe_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_sva (
    input logic             iw_clk,
    input logic             iw_rst,
    input logic             stall,
    input isa_pkg::opcode_t in_opc,
    input logic             mem_mp,
    input logic             wb_we,
    input logic             trap_out
);
    import isa_pkg::*;

    logic in_mem;

    assign in_mem = (in_opc == OPC_LD) || (in_opc == OPC_ST);

    // A trapped instruction is cancelled and never writes a register
    wb_trap_exclusive: assert property (
        @(posedge iw_clk) disable iff (iw_rst) !(wb_we && trap_out)
    ) else $error("wb_we and trap_out are high in the same cycle");

    // An edge taken under stall retires nothing
    quiet_after_stall: assert property (
        @(posedge iw_clk) disable iff (iw_rst) $past(stall) |-> (!wb_we && !trap_out)
    ) else $error("write-back or trap seen after a stalled edge");

    quiet_after_reset: assert property (
        @(posedge iw_clk) $fell(iw_rst) |-> (!wb_we && !trap_out)
    ) else $error("write-back or trap seen right after reset");

    // The port-select bit moves only for an accepted memory instruction
    mp_flip_has_cause: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        (mem_mp != $past(mem_mp)) |-> $past(!stall && in_mem)
    ) else $error("mem_mp flipped without an unstalled memory instruction");

    mp_flip_on_mem_op: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        $past(!stall && in_mem) |-> (mem_mp != $past(mem_mp))
    ) else $error("mem_mp did not flip after an unstalled memory instruction");

endmodule

`default_nettype wire

/* sim/tb_mem_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sizes_defines.svh"

module tb_mem_pipe;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_ALU      = 8;
    localparam int NUM_ST       = 8;
    localparam int NUM_PAIRS    = 4;
    localparam int STALL_LEN    = 5;
    // Issue slots of every test plus the drain at the end
    localparam int TEST_CYCLES  = 2 + NUM_ALU + 2 * NUM_ST + 2 * NUM_PAIRS + 4
                                  + 2 * (STALL_LEN + 3) + 4;
    localparam int WATCHDOG_NS  = 2 * (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        opcode_t opc;
        gp_idx_t tgt;
        logic    we;
        addr_t   addr;
        data_t   result;
        logic    trap;
    } instr_t;

    logic    iw_clk;
    logic    iw_rst;
    logic    stall;
    opcode_t in_opc;
    gp_idx_t in_tgt_gp;
    logic    in_tgt_gp_we;
    addr_t   in_addr;
    data_t   in_result;
    logic    in_trap_pending;
    logic    wb_we;
    gp_idx_t wb_tgt;
    data_t   wb_data;
    logic    trap_out;

    // Reference model state
    data_t       shadow_mem [`MEM_DEPTH];
    instr_t      pipe_q [$];
    logic        exp_wb_we;
    gp_idx_t     exp_wb_tgt;
    data_t       exp_wb_data;
    logic        exp_trap;
    logic [15:0] lfsr_state;
    addr_t       st_addr [NUM_ST];

    mem_pipe_top u_dut (
        .iw_clk          (iw_clk),
        .iw_rst          (iw_rst),
        .stall           (stall),
        .in_opc          (in_opc),
        .in_tgt_gp       (in_tgt_gp),
        .in_tgt_gp_we    (in_tgt_gp_we),
        .in_addr         (in_addr),
        .in_result       (in_result),
        .in_trap_pending (in_trap_pending),
        .wb_we           (wb_we),
        .wb_tgt          (wb_tgt),
        .wb_data         (wb_data),
        .trap_out        (trap_out)
    );

    bind mem_pipe_top mem_pipe_sva u_sva (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .stall    (stall),
        .in_opc   (in_opc),
        .mem_mp   (mem_mp),
        .wb_we    (wb_we),
        .trap_out (trap_out)
    );

    initial begin
        iw_clk = 1'b0;
        forever #(CLK_PERIOD / 2) iw_clk = ~iw_clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic rand_fields(output addr_t a, output data_t d, output gp_idx_t t,
                               output logic b);
        logic [31:0] v;
        rand_bits(`SIZE_ADDR, v);
        a = addr_t'(v);
        rand_bits(`SIZE_DATA, v);
        d = data_t'(v);
        rand_bits(`SIZE_TGT_GP, v);
        t = gp_idx_t'(v);
        rand_bits(1, v);
        b = v[0];
    endtask

    // A held instruction stays on the inputs until release_stall drops stall
    task automatic issue(input opcode_t opc, input gp_idx_t tgt, input logic we,
                         input addr_t addr, input data_t res, input logic trap,
                         input logic hold);
        @(posedge iw_clk);
        stall           <= hold;
        in_opc          <= opc;
        in_tgt_gp       <= tgt;
        in_tgt_gp_we    <= we;
        in_addr         <= addr;
        in_result       <= res;
        in_trap_pending <= trap;
    endtask

    task automatic release_stall(input int cycles);
        repeat (cycles) @(posedge iw_clk);
        stall <= 1'b0;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("FAIL at %0d ns: %s expected %0h got %0h", $time, name, exp_val, act_val);
        $display("SOME TESTS FAILED");
        $fatal(1, "Mismatch on %s", name);
    endtask

    // Retire one instruction per unstalled edge, two edges after it was presented
    always @(posedge iw_clk or posedge iw_rst) begin : ref_model
        instr_t cur;
        instr_t old;
        if (iw_rst) begin
            pipe_q.delete();
            exp_wb_we   <= 1'b0;
            exp_trap    <= 1'b0;
            exp_wb_tgt  <= '0;
            exp_wb_data <= '0;
        end else begin
            exp_wb_we <= 1'b0;
            exp_trap  <= 1'b0;
            if (!stall) begin
                cur.opc    = in_opc;
                cur.tgt    = in_tgt_gp;
                cur.we     = in_tgt_gp_we;
                cur.addr   = in_addr;
                cur.result = in_result;
                cur.trap   = in_trap_pending;
                pipe_q.push_back(cur);
                if (pipe_q.size() > 1) begin
                    old = pipe_q.pop_front();
                    if (old.trap) begin
                        exp_trap <= 1'b1;
                    end else if (old.opc == OPC_ST) begin
                        shadow_mem[old.addr] = old.result;
                    end else if (old.opc == OPC_ALU && old.we) begin
                        exp_wb_we   <= 1'b1;
                        exp_wb_tgt  <= old.tgt;
                        exp_wb_data <= old.result;
                    end else if (old.opc == OPC_LD && old.we) begin
                        exp_wb_we   <= 1'b1;
                        exp_wb_tgt  <= old.tgt;
                        exp_wb_data <= shadow_mem[old.addr];
                    end
                end
            end
        end
    end

    chk_wb_we: assert property (@(posedge iw_clk) disable iff (iw_rst) wb_we == exp_wb_we)
        else report_mismatch("wb_we", 32'($sampled(exp_wb_we)), 32'($sampled(wb_we)));

    chk_trap: assert property (@(posedge iw_clk) disable iff (iw_rst) trap_out == exp_trap)
        else report_mismatch("trap_out", 32'($sampled(exp_trap)), 32'($sampled(trap_out)));

    chk_wb_tgt: assert property (
        @(posedge iw_clk) disable iff (iw_rst) exp_wb_we |-> (wb_tgt == exp_wb_tgt)
    ) else report_mismatch("wb_tgt", 32'($sampled(exp_wb_tgt)), 32'($sampled(wb_tgt)));

    chk_wb_data: assert property (
        @(posedge iw_clk) disable iff (iw_rst) exp_wb_we |-> (wb_data == exp_wb_data)
    ) else report_mismatch("wb_data", 32'($sampled(exp_wb_data)), 32'($sampled(wb_data)));

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the stimulus finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation timed out");
    end

    initial begin
        addr_t   a;
        data_t   d;
        gp_idx_t t;
        logic    b;
        lfsr_state = 16'd6946;
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            shadow_mem[i] = '0;
        end
        iw_rst          = 1'b1;
        stall           = 1'b0;
        in_opc          = OPC_NOP;
        in_tgt_gp       = '0;
        in_tgt_gp_we    = 1'b0;
        in_addr         = '0;
        in_result       = '0;
        in_trap_pending = 1'b0;
        repeat (RESET_CYCLES) @(posedge iw_clk);
        iw_rst <= 1'b0;

        // Fresh memory reads back as zero
        for (int i = 0; i < 2; i++) begin
            rand_fields(a, d, t, b);
            issue(OPC_LD, t, 1'b1, a, d, 1'b0, 1'b0);
        end
        for (int i = 0; i < NUM_ALU; i++) begin
            rand_fields(a, d, t, b);
            issue(OPC_ALU, t, b, a, d, 1'b0, 1'b0);
        end
        for (int i = 0; i < NUM_ST; i++) begin
            rand_fields(a, d, t, b);
            st_addr[i] = a;
            issue(OPC_ST, t, 1'b1, a, d, 1'b0, 1'b0);
        end
        for (int i = 0; i < NUM_ST; i++) begin
            rand_fields(a, d, t, b);
            issue(OPC_LD, t, 1'b1, st_addr[i], d, 1'b0, 1'b0);
        end
        // Load in the slot right behind a store to the same word
        for (int i = 0; i < NUM_PAIRS; i++) begin
            rand_fields(a, d, t, b);
            issue(OPC_ST, t, 1'b1, a, d, 1'b0, 1'b0);
            issue(OPC_LD, t, 1'b1, a, ~d, 1'b0, 1'b0);
        end

        // The trapped store must leave the first value in place
        rand_fields(a, d, t, b);
        issue(OPC_ST, t, 1'b1, a, d, 1'b0, 1'b0);
        issue(OPC_ST, t, 1'b1, a, ~d, 1'b1, 1'b0);
        issue(OPC_LD, t, 1'b1, a, d, 1'b1, 1'b0);
        issue(OPC_LD, t, 1'b1, a, d, 1'b0, 1'b0);

        // Stalls with an ALU op and then a load waiting in MA
        rand_fields(a, d, t, b);
        issue(OPC_ALU, t, 1'b1, a, d, 1'b0, 1'b0);
        rand_fields(a, d, t, b);
        issue(OPC_ALU, t, 1'b1, a, d, 1'b0, 1'b1);
        release_stall(STALL_LEN);
        rand_fields(a, d, t, b);
        issue(OPC_LD, t, 1'b1, st_addr[0], d, 1'b0, 1'b0);
        rand_fields(a, d, t, b);
        issue(OPC_ST, t, 1'b1, a, d, 1'b0, 1'b1);
        release_stall(STALL_LEN);
        issue(OPC_LD, t, 1'b1, a, ~d, 1'b0, 1'b0);

        issue(OPC_NOP, '0, 1'b0, '0, '0, 1'b0, 1'b0);
        issue(OPC_NOP, '0, 1'b0, '0, '0, 1'b0, 1'b0);
        repeat (2) @(posedge iw_clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
